/* chiplet_tx_arb.f */
+incdir+src
src/phy_types_pkg.sv
src/chiplet_types_pkg.sv
src/arb_ifs.sv
src/arb_counter.sv
src/arb_que.sv
src/arbitration_buffer.sv
src/tx_framer.sv
src/chiplet_tx_arb.sv
tb/chiplet_tx_arb_tb.sv

/* run.sh */
#!/bin/sh
# build and run the chiplet_tx_arb testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module chiplet_tx_arb_tb \
    -f chiplet_tx_arb.f -o chiplet_tx_arb_sim

./obj_dir/chiplet_tx_arb_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi

/* src/arb_config.svh */
`ifndef ARB_CONFIG_SVH
`define ARB_CONFIG_SVH

// pending-symbol counter width, saturates at all ones
`define ARB_CNT_BITS 4

// ack header queue entries, power of two
`define ARB_QUE_DEPTH 8

// flit and output word width
`define FLIT_BITS 32

`endif

/* src/arb_counter.sv */
`timescale 1ns/1ps

module arb_counter (
    input  logic               CLK,
    input  logic               nRST,
    arb_counter_if.counter     cnt_if
);

    logic inc;
    logic dec;

    // full level, held while at max
    assign cnt_if.overflow = &cnt_if.count;

    // writes dropped once saturated
    assign inc = cnt_if.en & ~cnt_if.overflow;
    // never below zero
    assign dec = cnt_if.dec & (|cnt_if.count);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt_if.count <= '0;
        end else begin
            // inc and dec together cancel
            case ({inc, dec})
                2'b10: cnt_if.count <= cnt_if.count + 1'b1;
                2'b01: cnt_if.count <= cnt_if.count - 1'b1;
                default: cnt_if.count <= cnt_if.count;
            endcase
        end
    end

endmodule

/* src/arb_ifs.sv */
`timescale 1ns/1ps

`include "arb_config.svh"

// pending control symbol counter
interface arb_counter_if;
    logic                     en;
    logic                     dec;
    logic [`ARB_CNT_BITS-1:0] count;
    logic                     overflow;

    modport counter (input en, dec, output count, overflow);
    // en and the full flag are handled at the top
    modport arbiter (output dec, input count);
endinterface

// ack header queue
interface arb_que_if;
    import chiplet_types_pkg::*;

    logic  push;
    logic  pop;
    flit_t push_data;
    flit_t head;
    logic  full;

    modport que (input push, pop, push_data, output head, full);
    modport arbiter (output pop, input head);
endinterface

// arbiter to framer, one symbol request at a time
interface arbitration_buffer_if;
    import phy_types_pkg::*;
    import chiplet_types_pkg::*;

    logic       start;
    comma_sel_t comma_sel;
    flit_t      comma_header_out;
    logic       done;

    modport arb (output start, comma_sel, comma_header_out, input done);
    modport framer (input start, comma_sel, comma_header_out, output done);
endinterface

/* src/arb_que.sv */
`timescale 1ns/1ps

`include "arb_config.svh"

module arb_que (
    input  logic    CLK,
    input  logic    nRST,
    arb_que_if.que  que_if
);
    import chiplet_types_pkg::*;

    localparam int PTR_BITS = $clog2(`ARB_QUE_DEPTH);

    flit_t               mem [`ARB_QUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   occ;
    logic                do_push;
    logic                do_pop;

    assign que_if.full = (occ == (PTR_BITS+1)'(`ARB_QUE_DEPTH));
    // push into a full queue is lost
    assign do_push = que_if.push & ~que_if.full;
    assign do_pop  = que_if.pop & (|occ);

    // oldest entry always visible
    assign que_if.head = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= que_if.push_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: occ <= occ + 1'b1;
                2'b01: occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

endmodule

/* src/arbitration_buffer.sv */
`timescale 1ns/1ps

module arbitration_buffer (
    input  logic                     CLK,
    input  logic                     nRST,
    arbitration_buffer_if.arb        arb_if,
    arb_counter_if.arbiter           grtcred0_if,
    arb_counter_if.arbiter           grtcred1_if,
    arb_counter_if.arbiter           ack_if,
    arb_que_if.arbiter               que_if,
    input  logic                     data_write,
    input  logic                     send_new_data,
    input  chiplet_types_pkg::flit_t flit_data,
    output logic                     get_data
);
    import phy_types_pkg::*;
    import chiplet_types_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SENDING_COMMA,
        SENDING_START,
        STALL_DATA_SEND,
        SENDING_DATA,
        SENDING_END
    } arb_state_t;

    arb_state_t state, n_state;
    // low means control symbols own the turn
    logic       data_turn, n_data_turn;
    // latched data_write, one packet waiting
    logic       data_pending, n_data_pending;
    // which control symbol is in flight
    comma_sel_t sent_sel, n_sent_sel;
    logic [8:0] packet_size, n_packet_size;
    // data flits sent in the current packet
    logic [8:0] data_cnt, n_data_cnt;
    flit_hdr_u  hdr;

    // header flit seen through both formats
    assign hdr = flit_hdr_u'(flit_data);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state        <= IDLE;
            data_turn    <= 1'b0;
            data_pending <= 1'b0;
            sent_sel     <= NADA_SEL;
            packet_size  <= '0;
            data_cnt     <= '0;
        end else begin
            state        <= n_state;
            data_turn    <= n_data_turn;
            data_pending <= n_data_pending;
            sent_sel     <= n_sent_sel;
            packet_size  <= n_packet_size;
            data_cnt     <= n_data_cnt;
        end
    end

    always_comb begin
        n_state        = state;
        n_data_turn    = data_turn;
        n_data_pending = data_pending | data_write;
        n_sent_sel     = sent_sel;
        n_packet_size  = packet_size;
        n_data_cnt     = data_cnt;
        arb_if.start            = 1'b0;
        arb_if.comma_sel        = NADA_SEL;
        arb_if.comma_header_out = '0;
        grtcred0_if.dec = 1'b0;
        grtcred1_if.dec = 1'b0;
        ack_if.dec      = 1'b0;
        que_if.pop      = 1'b0;
        get_data        = 1'b0;
        case (state)
            IDLE: begin
                // turn flips on every idle cycle
                n_data_turn = ~data_turn;
                if (!data_turn) begin
                    // fixed priority among control symbols
                    if (grtcred0_if.count != '0) begin
                        arb_if.start     = 1'b1;
                        arb_if.comma_sel = GRTCRED0_SEL;
                    end else if (grtcred1_if.count != '0) begin
                        arb_if.start     = 1'b1;
                        arb_if.comma_sel = GRTCRED1_SEL;
                    end else if (ack_if.count != '0) begin
                        arb_if.start            = 1'b1;
                        arb_if.comma_sel        = ACK_SEL;
                        arb_if.comma_header_out = que_if.head;
                        que_if.pop              = 1'b1;
                    end
                    if (arb_if.start) begin
                        n_sent_sel = arb_if.comma_sel;
                        n_state    = SENDING_COMMA;
                    end
                end else if (data_pending) begin
                    // header flit goes out with START
                    arb_if.start     = 1'b1;
                    arb_if.comma_sel = START_PACKET_SEL;
                    n_data_pending   = data_write;
                    n_state          = SENDING_START;
                end
            end
            SENDING_COMMA: begin
                if (arb_if.done) begin
                    // retire the symbol that was actually sent
                    case (sent_sel)
                        GRTCRED0_SEL: grtcred0_if.dec = 1'b1;
                        GRTCRED1_SEL: grtcred1_if.dec = 1'b1;
                        ACK_SEL:      ack_if.dec      = 1'b1;
                        default:      ;
                    endcase
                    n_state = IDLE;
                end
            end
            SENDING_START: begin
                if (arb_if.done) begin
                    // header still held by the source here
                    get_data      = 1'b1;
                    n_packet_size = packet_flits(hdr);
                    n_data_cnt    = '0;
                    n_state       = STALL_DATA_SEND;
                end
            end
            STALL_DATA_SEND: begin
                // END once all body flits are out
                if (data_cnt == packet_size - 9'd1) begin
                    arb_if.start     = 1'b1;
                    arb_if.comma_sel = END_PACKET_SEL;
                    n_state          = SENDING_END;
                end else if (send_new_data) begin
                    arb_if.start     = 1'b1;
                    arb_if.comma_sel = DATA_SEL;
                    n_state          = SENDING_DATA;
                end
            end
            SENDING_DATA: begin
                if (arb_if.done) begin
                    get_data   = 1'b1;
                    n_data_cnt = data_cnt + 9'd1;
                    n_state    = STALL_DATA_SEND;
                end
            end
            SENDING_END: begin
                if (arb_if.done) begin
                    n_state = IDLE;
                end
            end
            default: n_state = IDLE;
        endcase
    end

endmodule

/* src/chiplet_tx_arb.sv */
`timescale 1ns/1ps

module chiplet_tx_arb (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       ack_write,
    input  chiplet_types_pkg::flit_t   rx_header,
    input  logic                       grtcred0_write,
    input  logic                       grtcred1_write,
    input  logic                       data_write,
    input  logic                       send_new_data,
    input  chiplet_types_pkg::flit_t   flit_data,
    output logic                       ack_cnt_full,
    output logic                       grtcred_0_full,
    output logic                       grtcred_1_full,
    output logic                       get_data,
    output logic                       tx_valid,
    output phy_types_pkg::comma_sel_t  tx_sel,
    output chiplet_types_pkg::flit_t   tx_word
);

    arb_counter_if        ack_cnt_if ();
    arb_counter_if        grtcred0_if ();
    arb_counter_if        grtcred1_if ();
    arb_que_if            ack_que_if ();
    arbitration_buffer_if arb_if ();

    // write strobes bump the pending counts
    assign ack_cnt_if.en  = ack_write;
    assign grtcred0_if.en = grtcred0_write;
    assign grtcred1_if.en = grtcred1_write;

    // each ack queues the header it answers
    assign ack_que_if.push      = ack_write;
    assign ack_que_if.push_data = rx_header;

    assign ack_cnt_full   = ack_cnt_if.overflow;
    assign grtcred_0_full = grtcred0_if.overflow;
    assign grtcred_1_full = grtcred1_if.overflow;

    arb_counter ack_cnt (.CLK(CLK), .nRST(nRST), .cnt_if(ack_cnt_if));
    arb_counter grtcred0_cnt (.CLK(CLK), .nRST(nRST), .cnt_if(grtcred0_if));
    arb_counter grtcred1_cnt (.CLK(CLK), .nRST(nRST), .cnt_if(grtcred1_if));

    arb_que ack_que (.CLK(CLK), .nRST(nRST), .que_if(ack_que_if));

    arbitration_buffer arb (
        .CLK           (CLK),
        .nRST          (nRST),
        .arb_if        (arb_if),
        .grtcred0_if   (grtcred0_if),
        .grtcred1_if   (grtcred1_if),
        .ack_if        (ack_cnt_if),
        .que_if        (ack_que_if),
        .data_write    (data_write),
        .send_new_data (send_new_data),
        .flit_data     (flit_data),
        .get_data      (get_data)
    );

    tx_framer framer (
        .CLK       (CLK),
        .nRST      (nRST),
        .arb_if    (arb_if),
        .flit_data (flit_data),
        .tx_valid  (tx_valid),
        .tx_sel    (tx_sel),
        .tx_word   (tx_word)
    );

endmodule

/* src/chiplet_types_pkg.sv */
`include "arb_config.svh"

package chiplet_types_pkg;

    typedef logic [`FLIT_BITS-1:0] flit_t;

    typedef enum logic [3:0] {
        FMT_LONG_READ   = 4'h0,
        FMT_LONG_WRITE  = 4'h1,
        FMT_SHORT_READ  = 4'h4,
        FMT_SHORT_WRITE = 4'h5
    } fmt_t;

    // format sits in the top nibble of both views
    typedef struct packed {
        fmt_t        fmt;
        logic [6:0]  length;
        logic [20:0] addr;
    } long_hdr_t;

    typedef struct packed {
        fmt_t        fmt;
        logic [3:0]  length;
        logic [23:0] addr;
    } short_hdr_t;

    typedef union packed {
        long_hdr_t  long_hdr;
        short_hdr_t short_hdr;
    } flit_hdr_u;

    // total flits of a packet, header included
    function automatic logic [8:0] packet_flits(flit_hdr_u hdr);
        case (hdr.long_hdr.fmt)
            FMT_LONG_READ:   return 9'd3;
            // zero length encodes 128
            FMT_LONG_WRITE:  return 9'd3 + ((|hdr.long_hdr.length) ?
                                 {2'b00, hdr.long_hdr.length} : 9'd128);
            FMT_SHORT_READ:  return 9'd2;
            // zero length encodes 16
            FMT_SHORT_WRITE: return 9'd2 + ((|hdr.short_hdr.length) ?
                                 {5'b00000, hdr.short_hdr.length} : 9'd16);
            default:         return 9'd1;
        endcase
    endfunction

endpackage

/* src/phy_types_pkg.sv */
package phy_types_pkg;

    // kind of symbol on the transmit path
    typedef enum logic [2:0] {
        // nothing on the line
        NADA_SEL         = 3'd0,
        // grant credit, virtual channel 0
        GRTCRED0_SEL     = 3'd1,
        // grant credit, virtual channel 1
        GRTCRED1_SEL     = 3'd2,
        // acknowledge, carries a receive header
        ACK_SEL          = 3'd3,
        // packet open, carries the header flit
        START_PACKET_SEL = 3'd4,
        // packet body
        DATA_SEL         = 3'd5,
        // packet close
        END_PACKET_SEL   = 3'd6
    } comma_sel_t;

endpackage

/* src/tx_framer.sv */
`timescale 1ns/1ps

module tx_framer (
    input  logic                            CLK,
    input  logic                            nRST,
    arbitration_buffer_if.framer            arb_if,
    input  chiplet_types_pkg::flit_t        flit_data,
    output logic                            tx_valid,
    output phy_types_pkg::comma_sel_t       tx_sel,
    output chiplet_types_pkg::flit_t        tx_word
);
    import phy_types_pkg::*;

    // symbol is on the line for one cycle, done with it
    assign arb_if.done = tx_valid;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tx_valid <= 1'b0;
            tx_sel   <= NADA_SEL;
        end else begin
            tx_valid <= arb_if.start;
            tx_sel   <= arb_if.start ? arb_if.comma_sel : NADA_SEL;
        end
    end

    // payload word per symbol kind
    always_ff @(posedge CLK) begin
        if (arb_if.start) begin
            case (arb_if.comma_sel)
                ACK_SEL:          tx_word <= arb_if.comma_header_out;
                START_PACKET_SEL,
                DATA_SEL:         tx_word <= flit_data;
                // credits and END carry no payload
                default:          tx_word <= '0;
            endcase
        end
    end

endmodule

/* tb/chiplet_tx_arb_tb.sv */
`timescale 1ns/1ps

`include "arb_config.svh"

module chiplet_tx_arb_tb;
    import phy_types_pkg::*;
    import chiplet_types_pkg::*;

    localparam int CNT_MAX = (1 << `ARB_CNT_BITS) - 1;

    logic       CLK;
    logic       nRST;
    logic       ack_write;
    flit_t      rx_header;
    logic       grtcred0_write;
    logic       grtcred1_write;
    logic       data_write;
    logic       send_new_data;
    flit_t      flit_data;
    logic       ack_cnt_full;
    logic       grtcred_0_full;
    logic       grtcred_1_full;
    logic       get_data;
    logic       tx_valid;
    comma_sel_t tx_sel;
    flit_t      tx_word;

    // expected symbols in line order
    comma_sel_t exp_sel_q[$];
    flit_t      exp_word_q[$];
    // strobes planned for the next phase
    int         plan_gc0;
    int         plan_gc1;
    flit_t      plan_ack_q[$];
    int         plan_pkt_q[$];
    // source contents with packets back to back
    flit_t      src_flits[$];
    int         src_idx;
    logic       hold_stall;
    int         gd_count;
    int         gd_base;
    int         error_count;
    int         timeout_count;
    int         check_count;
    flit_t      hdr;

    chiplet_tx_arb chiplet_tx_arb_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .ack_write      (ack_write),
        .rx_header      (rx_header),
        .grtcred0_write (grtcred0_write),
        .grtcred1_write (grtcred1_write),
        .data_write     (data_write),
        .send_new_data  (send_new_data),
        .flit_data      (flit_data),
        .ack_cnt_full   (ack_cnt_full),
        .grtcred_0_full (grtcred_0_full),
        .grtcred_1_full (grtcred_1_full),
        .get_data       (get_data),
        .tx_valid       (tx_valid),
        .tx_sel         (tx_sel),
        .tx_word        (tx_word)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // flit count from the header format rule
    function automatic int ref_packet_flits(input flit_t h);
        int len;
        case (h[31:28])
            FMT_LONG_READ:  return 3;
            FMT_LONG_WRITE: begin
                len = int'(h[27:21]);
                return 3 + ((len == 0) ? 128 : len);
            end
            FMT_SHORT_READ: return 2;
            FMT_SHORT_WRITE: begin
                len = int'(h[27:24]);
                return 2 + ((len == 0) ? 16 : len);
            end
            default: return 1;
        endcase
    endfunction

    function automatic void push_symbol(input comma_sel_t sel, input flit_t word);
        exp_sel_q.push_back(sel);
        exp_word_q.push_back(word);
    endfunction

    // header plus random body words
    function automatic void plan_packet(input flit_t h);
        int n;
        n = ref_packet_flits(h);
        plan_pkt_q.push_back(src_flits.size());
        src_flits.push_back(h);
        for (int i = 1; i < n; i++) begin
            src_flits.push_back($urandom());
        end
    endfunction

    // pending count after writes into a counter that stops at its maximum
    function automatic int saturate_count(input int count, input int writes);
        int result;
        result = count;
        for (int i = 0; i < writes; i++) begin
            if (result < CNT_MAX) begin
                result++;
            end
        end
        return result;
    endfunction

    // expected order from the turn, priority and sizing rules
    function automatic void ref_symbol_list(input bit control_first);
        bit ctl_turn;
        int g0;
        int g1;
        int ai;
        int pi;
        int s;
        int n;
        ctl_turn = control_first;
        g0 = plan_gc0;
        g1 = plan_gc1;
        ai = 0;
        pi = 0;
        while (g0 > 0 || g1 > 0 || ai < plan_ack_q.size() || pi < plan_pkt_q.size()) begin
            if (ctl_turn) begin
                // credit 0, then credit 1, then ack
                if (g0 > 0) begin
                    push_symbol(GRTCRED0_SEL, '0);
                    g0--;
                end else if (g1 > 0) begin
                    push_symbol(GRTCRED1_SEL, '0);
                    g1--;
                end else if (ai < plan_ack_q.size()) begin
                    push_symbol(ACK_SEL, plan_ack_q[ai]);
                    ai++;
                end
            end else if (pi < plan_pkt_q.size()) begin
                s = plan_pkt_q[pi];
                n = ref_packet_flits(src_flits[s]);
                push_symbol(START_PACKET_SEL, src_flits[s]);
                for (int i = 1; i < n; i++) begin
                    push_symbol(DATA_SEL, src_flits[s + i]);
                end
                push_symbol(END_PACKET_SEL, '0);
                pi++;
            end
            ctl_turn = !ctl_turn;
        end
        plan_gc0 = 0;
        plan_gc1 = 0;
        plan_ack_q.delete();
        plan_pkt_q.delete();
    endfunction

    // strobes held for a number of edges
    task automatic drive_strobes(input logic g1, input logic g0, input logic ack,
                                 input flit_t h, input logic dw, input int cycles);
        @(posedge CLK);
        #1;
        grtcred1_write = g1;
        grtcred0_write = g0;
        ack_write      = ack;
        rx_header      = h;
        data_write     = dw;
        repeat (cycles) @(posedge CLK);
        #1;
        grtcred1_write = 1'b0;
        grtcred0_write = 1'b0;
        ack_write      = 1'b0;
        data_write     = 1'b0;
    endtask

    task automatic wait_symbol(input comma_sel_t sel, input int limit);
        int  cycles;
        bit  seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge CLK);
            seen = tx_valid && (tx_sel == sel);
            cycles++;
        end
        if (!seen) begin
            timeout_count++;
            $display("timeout after %0d cycles waiting for %s", limit, sel.name());
        end
    endtask

    // wait for every expected symbol and then watch a quiet window for extras
    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (exp_sel_q.size() != 0 && cycles < limit) begin
            @(negedge CLK);
            cycles++;
        end
        if (exp_sel_q.size() != 0) begin
            timeout_count++;
            $display("timeout with %0d expected symbols never sent", exp_sel_q.size());
        end
        repeat (8) @(negedge CLK);
    endtask

    // flit source that advances on get_data
    initial begin : flit_source
        logic took;
        flit_data     = '0;
        send_new_data = 1'b0;
        src_idx       = 0;
        forever begin
            @(negedge CLK);
            took = get_data;
            @(posedge CLK);
            #1;
            if (took) begin
                src_idx++;
            end
            if (src_idx < src_flits.size()) begin
                flit_data = src_flits[src_idx];
            end else begin
                flit_data = '0;
            end
            // random gaps and none at all while stalled
            send_new_data = !hold_stall && ($urandom_range(0, 3) != 0);
        end
    end

    initial begin : symbol_monitor
        comma_sel_t exp_sel;
        flit_t      exp_word;
        gd_count = 0;
        forever begin
            @(negedge CLK);
            if (nRST && get_data) begin
                gd_count++;
            end
            if (nRST && tx_valid) begin
                if (exp_sel_q.size() == 0) begin
                    error_count++;
                    $display("unexpected %s symbol at %0t", tx_sel.name(), $time);
                end else begin
                    exp_sel  = exp_sel_q.pop_front();
                    exp_word = exp_word_q.pop_front();
                    check_value("tx_sel", 32'(tx_sel), 32'(exp_sel));
                    check_value("tx_word", tx_word, exp_word);
                end
            end
        end
    end

    initial begin
        void'($urandom(12));
        nRST           = 1'b0;
        ack_write      = 1'b0;
        rx_header      = '0;
        grtcred0_write = 1'b0;
        grtcred1_write = 1'b0;
        data_write     = 1'b0;
        hold_stall     = 1'b0;
        plan_gc0       = 0;
        plan_gc1       = 0;
        error_count    = 0;
        timeout_count  = 0;
        check_count    = 0;
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // quiet line after reset
        @(negedge CLK);
        check_value("tx_sel", 32'(tx_sel), 32'(NADA_SEL));
        check_value("ack_cnt_full", 32'(ack_cnt_full), 32'd0);
        check_value("grtcred_0_full", 32'(grtcred_0_full), 32'd0);
        check_value("grtcred_1_full", 32'(grtcred_1_full), 32'd0);
        repeat (20) begin
            @(negedge CLK);
            check_value("tx_valid", 32'(tx_valid), 32'd0);
            check_value("get_data", 32'(get_data), 32'd0);
        end

        // all three control kinds at once
        plan_gc0 = 1;
        plan_gc1 = 1;
        plan_ack_q.push_back(32'hACC0_1234);
        ref_symbol_list(1'b1);
        drive_strobes(1'b1, 1'b1, 1'b1, 32'hACC0_1234, 1'b0, 1);
        wait_drain(200);

        // short write of length 3 carries four body flits
        hdr = {FMT_SHORT_WRITE, 4'd3, 24'h00_0040};
        plan_packet(hdr);
        ref_symbol_list(1'b0);
        gd_base = gd_count;
        drive_strobes(1'b0, 1'b0, 1'b0, '0, 1'b1, 1);
        wait_drain(500);
        check_value("get_data pulses", gd_count - gd_base, ref_packet_flits(hdr));

        // a lone credit first so that the data turn follows it
        plan_gc0 = 1;
        ref_symbol_list(1'b1);
        plan_gc0 = 1;
        plan_gc1 = 1;
        plan_ack_q.push_back(32'hACC0_5678);
        plan_packet({FMT_SHORT_WRITE, 4'd1, 24'h00_0100});
        plan_packet({FMT_LONG_READ, 7'd0, 21'h00_0200});
        ref_symbol_list(1'b1);
        drive_strobes(1'b0, 1'b1, 1'b0, '0, 1'b0, 1);
        wait_symbol(GRTCRED0_SEL, 50);
        drive_strobes(1'b1, 1'b1, 1'b1, 32'hACC0_5678, 1'b1, 1);
        // second packet latched while the first is on the line
        wait_symbol(START_PACKET_SEL, 50);
        drive_strobes(1'b0, 1'b0, 1'b0, '0, 1'b1, 1);
        wait_drain(500);

        // long write of max length with both credit counters saturating behind it
        hold_stall = 1'b1;
        hdr = {FMT_LONG_WRITE, 7'd0, 21'h01_0000};
        plan_packet(hdr);
        plan_gc0 = saturate_count(plan_gc0, CNT_MAX + 1);
        plan_gc1 = saturate_count(plan_gc1, CNT_MAX + 1);
        ref_symbol_list(1'b0);
        drive_strobes(1'b0, 1'b0, 1'b0, '0, 1'b1, 1);
        wait_symbol(START_PACKET_SEL, 50);
        drive_strobes(1'b1, 1'b1, 1'b0, '0, 1'b0, CNT_MAX + 1);
        @(negedge CLK);
        check_value("grtcred_0_full", 32'(grtcred_0_full), 32'd1);
        check_value("grtcred_1_full", 32'(grtcred_1_full), 32'd1);
        check_value("ack_cnt_full", 32'(ack_cnt_full), 32'd0);
        hold_stall = 1'b0;
        wait_drain(4000);
        check_value("grtcred_0_full", 32'(grtcred_0_full), 32'd0);
        check_value("grtcred_1_full", 32'(grtcred_1_full), 32'd0);

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
